// ==== hw/snes_loader_config.svh ====
`ifndef SNES_LOADER_CONFIG_SVH
`define SNES_LOADER_CONFIG_SVH

// ==================================================
// Download stream indexes
// ==================================================
// Cartridge and SPC indexes compare on index[5:0]
`define SNES_IDX_CART 6'd0
`define SNES_IDX_SPC 6'd1
`define SNES_IDX_CODE 8'hFF

// ==================================================
// Cartridge header layout
// ==================================================
// Copier header in front of the image
`define SNES_HDR_SKIP 25'h000200
// ROM size field, RAM size field sits at +2
`define SNES_LOROM_HDR 25'h007FD6
`define SNES_HIROM_HDR 25'h00FFD6
`define SNES_EXHIROM_HDR 25'h40FFD6

`define SNES_DEF_ROM_SIZE 4'hC
`define SNES_SIZE_UNIT 24'd1024

// Address bits swept by the RAM clear
`define SNES_CLEAR_BITS 17

`endif

// ==== hw/snes_loader_pkg.sv ====
package snes_loader_pkg;

	// ==================================================
	// Host download stream
	// ==================================================
	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [15:0] data;
		logic        wr;
	} ioctl_bus_t;

	// Header handling selected from the menu
	typedef enum logic [2:0] {
		MAP_AUTO    = 3'd0,
		MAP_NONE    = 3'd1,
		MAP_LOROM   = 3'd2,
		MAP_HIROM   = 3'd3,
		MAP_EXHIROM = 3'd4
	} map_mode_e;

	typedef enum logic [1:0] {
		REGION_AUTO = 2'd0,
		REGION_NTSC = 2'd1,
		REGION_PAL  = 2'd2
	} region_sel_e;

	// Power-on RAM contents
	typedef enum logic [1:0] {
		FILL_9966 = 2'd0,
		FILL_00FF = 2'd1,
		FILL_55   = 2'd2,
		FILL_FF   = 2'd3
	} fill_mode_e;

	// ==================================================
	// Results
	// ==================================================
	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
	} cart_info_t;

	// Valid strobe on top, then the four 32-bit fields
	typedef struct packed {
		logic        valid;
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef logic signed [15:0] audio_sample_t;

	typedef struct packed {
		audio_sample_t left;
		audio_sample_t right;
	} stereo_t;

endpackage

// ==== hw/rom_header_detect.sv ====
`timescale 1ns/100ps
`include "snes_loader_config.svh"

module rom_header_detect (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         cart_active,
	input  snes_loader_pkg::ioctl_bus_t  ioctl,
	input  snes_loader_pkg::map_mode_e   map_mode,
	input  snes_loader_pkg::region_sel_e region_sel,
	output snes_loader_pkg::cart_info_t  cart,
	output logic                         pal
);

	import snes_loader_pkg::*;

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;
	logic [24:0] size_addr;
	logic        size_en;
	logic        hdr_wr;

	assign hdr_wr = cart_active & ioctl.wr;

	// Location of the size fields for a forced mapping
	always_comb begin
		size_en = 1'b1;
		case (map_mode)
			MAP_LOROM: size_addr = `SNES_LOROM_HDR + `SNES_HDR_SKIP;
			MAP_HIROM: size_addr = `SNES_HIROM_HDR + `SNES_HDR_SKIP;
			MAP_EXHIROM: size_addr = `SNES_EXHIROM_HDR + `SNES_HDR_SKIP;
			default: begin
				size_addr = '0;
				size_en = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size <= `SNES_DEF_ROM_SIZE;
			ram_size <= 4'd0;
			rom_region <= 1'b0;
			cart <= '0;
			pal <= 1'b0;
		end else begin
			if (hdr_wr) begin
				if (ioctl.addr == 25'd0) begin
					rom_size <= `SNES_DEF_ROM_SIZE;
					ram_size <= 4'd0;
					// Auto mode takes both codes from the first byte
					if (map_mode == MAP_AUTO && ioctl.data[7:0] != 8'd0) begin
						{ram_size, rom_size} <= ioctl.data[7:0];
					end
					case (map_mode)
						MAP_NONE,
						MAP_LOROM: cart.rom_type <= 8'd0;
						MAP_HIROM: cart.rom_type <= 8'd1;
						MAP_EXHIROM: cart.rom_type <= 8'd2;
						default: cart.rom_type <= ioctl.data[15:8];
					endcase
				end

				if (ioctl.addr == 25'd2) begin
					rom_region <= ioctl.data[8];
				end

				if (size_en && ioctl.addr == size_addr) begin
					rom_size <= ioctl.data[11:8];
				end
				if (size_en && ioctl.addr == size_addr + 25'd2) begin
					ram_size <= ioctl.data[3:0];
				end
			end

			// Second stage, masks lag the size codes by one cycle
			cart.rom_mask <= (`SNES_SIZE_UNIT << rom_size) - 24'd1;
			cart.ram_mask <= (ram_size != 4'd0) ? (`SNES_SIZE_UNIT << ram_size) - 24'd1 : 24'd0;

			// Region frozen during the download
			if (!cart_active) begin
				pal <= (region_sel == REGION_AUTO) ? rom_region : (region_sel == REGION_PAL);
			end
		end
	end

endmodule

// ==== hw/cheat_code_assembler.sv ====
`timescale 1ns/100ps
`include "snes_loader_config.svh"

module cheat_code_assembler (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         code_active,
	input  snes_loader_pkg::ioctl_bus_t  ioctl,
	output snes_loader_pkg::cheat_code_t cheat
);

	import snes_loader_pkg::*;

	logic        code_wr;
	logic        valid_q;
	logic [31:0] flags_q;
	logic [31:0] addr_q;
	logic [31:0] compare_q;
	logic [31:0] replace_q;

	assign code_wr = code_active & ioctl.wr;

	// Last word of the code strobes it out
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= code_wr && ioctl.addr[3:0] == 4'd14;
		end
	end

	// Low half first, then high half of each field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl.addr[3:0])
				4'd0: flags_q[15:0] <= ioctl.data;
				4'd2: flags_q[31:16] <= ioctl.data;
				4'd4: addr_q[15:0] <= ioctl.data;
				4'd6: addr_q[31:16] <= ioctl.data;
				4'd8: compare_q[15:0] <= ioctl.data;
				4'd10: compare_q[31:16] <= ioctl.data;
				4'd12: replace_q[15:0] <= ioctl.data;
				4'd14: replace_q[31:16] <= ioctl.data;
				default: ;
			endcase
		end
	end

	assign cheat = cheat_code_t'{valid: valid_q, flags: flags_q, addr: addr_q,
		compare: compare_q, replace: replace_q};

endmodule

// ==== hw/ram_clear_engine.sv ====
`timescale 1ns/100ps
`include "snes_loader_config.svh"

module ram_clear_engine (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  logic                          cart_active,
	input  snes_loader_pkg::fill_mode_e   wram_fill,
	input  snes_loader_pkg::fill_mode_e   aram_fill,
	output logic                          clearing,
	output logic [`SNES_CLEAR_BITS-1:0]   fill_addr,
	output logic [7:0]                    wram_data,
	output logic [7:0]                    aram_data
);

	import snes_loader_pkg::*;

	logic cart_active_d;
	logic load_start;

	// Power-on pattern of the console revisions
	function automatic logic [7:0] fill_byte(
		input fill_mode_e                  mode,
		input logic [`SNES_CLEAR_BITS-1:0] addr
	);
		logic [7:0] value;
		case (mode)
			FILL_9966: value = (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			FILL_00FF: value = (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			FILL_55: value = 8'h55;
			default: value = 8'hFF;
		endcase
		return value;
	endfunction

	assign load_start = cart_active & ~cart_active_d;

	// ==================================================
	// Sweep control
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_active_d <= 1'b0;
			clearing <= 1'b0;
			fill_addr <= '0;
		end else begin
			cart_active_d <= cart_active;

			if (load_start) begin
				clearing <= 1'b1;
			end
			// Last address written, sweep done
			if (&fill_addr) begin
				clearing <= 1'b0;
			end

			if (clearing) begin
				fill_addr <= fill_addr + 1'b1;
			end else begin
				fill_addr <= '0;
			end
		end
	end

	assign wram_data = fill_byte(wram_fill, fill_addr);
	assign aram_data = fill_byte(aram_fill, fill_addr);

endmodule

// ==== hw/audio_sat_mixer.sv ====
`timescale 1ns/100ps

module audio_sat_mixer (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  snes_loader_pkg::stereo_t main_in,
	input  snes_loader_pkg::stereo_t aux_in,
	output snes_loader_pkg::stereo_t mix_out
);

	import snes_loader_pkg::*;

	// Clip to full scale when the top two sum bits disagree
	function automatic audio_sample_t sat_add(
		input audio_sample_t a,
		input audio_sample_t b
	);
		logic signed [16:0] sum;
		sum = 17'(a) + 17'(b);
		if (sum[16] ^ sum[15]) begin
			return sum[16] ? 16'sh8000 : 16'sh7FFF;
		end
		return sum[15:0];
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			mix_out <= '0;
		end else begin
			mix_out.left <= sat_add(main_in.left, aux_in.left);
			mix_out.right <= sat_add(main_in.right, aux_in.right);
		end
	end

endmodule

// ==== hw/snes_loader_top.sv ====
`timescale 1ns/100ps
`include "snes_loader_config.svh"

module snes_loader_top (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  snes_loader_pkg::ioctl_bus_t   ioctl,
	input  snes_loader_pkg::map_mode_e    map_mode,
	input  snes_loader_pkg::region_sel_e  region_sel,
	input  snes_loader_pkg::fill_mode_e   wram_fill,
	input  snes_loader_pkg::fill_mode_e   aram_fill,
	input  snes_loader_pkg::stereo_t      main_audio,
	input  snes_loader_pkg::stereo_t      aux_audio,
	output snes_loader_pkg::cart_info_t   cart,
	output logic                          pal,
	output snes_loader_pkg::cheat_code_t  cheat,
	output logic                          clearing,
	output logic [`SNES_CLEAR_BITS-1:0]   fill_addr,
	output logic [7:0]                    wram_data,
	output logic [7:0]                    aram_data,
	output snes_loader_pkg::stereo_t      mix_audio,
	output logic                          system_reset
);

	import snes_loader_pkg::*;

	logic cart_active;
	logic spc_active;
	logic code_active;

	// ==================================================
	// Download index decode
	// ==================================================
	assign cart_active = ioctl.download && ioctl.index[5:0] == `SNES_IDX_CART;
	assign spc_active = ioctl.download && ioctl.index[5:0] == `SNES_IDX_SPC;
	assign code_active = ioctl.download && ioctl.index == `SNES_IDX_CODE;

	// Core held in reset while loading or clearing
	assign system_reset = RESET | cart_active | spc_active | clearing;

	rom_header_detect hdr_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_active(cart_active),
		.ioctl      (ioctl),
		.map_mode   (map_mode),
		.region_sel (region_sel),
		.cart       (cart),
		.pal        (pal)
	);

	cheat_code_assembler code_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.code_active(code_active),
		.ioctl      (ioctl),
		.cheat      (cheat)
	);

	ram_clear_engine clear_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_active(cart_active),
		.wram_fill  (wram_fill),
		.aram_fill  (aram_fill),
		.clearing   (clearing),
		.fill_addr  (fill_addr),
		.wram_data  (wram_data),
		.aram_data  (aram_data)
	);

	audio_sat_mixer mix_i (
		.clk_sys(clk_sys),
		.RESET  (RESET),
		.main_in(main_audio),
		.aux_in (aux_audio),
		.mix_out(mix_audio)
	);

endmodule

// ==== tb/tb_snes_loader.sv ====
`timescale 1ns/100ps
`include "snes_loader_config.svh"

module tb_snes_loader;

	import snes_loader_pkg::*;

	logic                        clk_sys;
	logic                        RESET;
	ioctl_bus_t                  ioctl;
	map_mode_e                   map_mode;
	region_sel_e                 region_sel;
	fill_mode_e                  wram_fill;
	fill_mode_e                  aram_fill;
	stereo_t                     main_audio;
	stereo_t                     aux_audio;
	cart_info_t                  cart;
	logic                        pal;
	cheat_code_t                 cheat;
	logic                        clearing;
	logic [`SNES_CLEAR_BITS-1:0] fill_addr;
	logic [7:0]                  wram_data;
	logic [7:0]                  aram_data;
	stereo_t                     mix_audio;
	logic                        system_reset;

	int errors;
	int checks;

	snes_loader_top dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Reference rules
	// ==================================================
	function automatic logic [23:0] size_mask(input logic [3:0] code, input logic zero_none);
		logic [23:0] mask;
		mask = `SNES_SIZE_UNIT << code;
		mask = mask - 24'd1;
		if (zero_none && code == 4'd0) begin
			mask = '0;
		end
		return mask;
	endfunction

	function automatic logic [7:0] expected_fill(input fill_mode_e mode,
		input logic [`SNES_CLEAR_BITS-1:0] addr);
		if (mode == FILL_55) begin
			return 8'h55;
		end
		if (mode == FILL_FF) begin
			return 8'hFF;
		end
		if (mode == FILL_00FF) begin
			return (addr[9] != addr[0]) ? 8'hFF : 8'h00;
		end
		return (addr[8] != addr[2]) ? 8'h66 : 8'h99;
	endfunction

	function automatic audio_sample_t clip_sum(input audio_sample_t a, input audio_sample_t b);
		int sum;
		sum = int'(a) + int'(b);
		if (sum > 32767) begin
			return 16'sh7FFF;
		end
		if (sum < -32768) begin
			return 16'sh8000;
		end
		return audio_sample_t'(sum);
	endfunction

	// ==================================================
	// Compare tasks
	// ==================================================
	task automatic report_mismatch(input string name, input logic [128:0] exp,
		input logic [128:0] act);
		errors++;
		$display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
	endtask

	task automatic check_cart(input string name, input cart_info_t exp, input cart_info_t act);
		checks++;
		if (act !== exp) begin
			report_mismatch(name, exp, act);
		end
	endtask

	task automatic check_cheat(input string name, input cheat_code_t exp,
		input cheat_code_t act);
		checks++;
		if (act !== exp) begin
			report_mismatch(name, exp, act);
		end
	endtask

	task automatic check_stereo(input string name, input stereo_t exp, input stereo_t act);
		checks++;
		if (act !== exp) begin
			report_mismatch(name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input logic [`SNES_CLEAR_BITS-1:0] exp,
		input logic [`SNES_CLEAR_BITS-1:0] act);
		checks++;
		if (act !== exp) begin
			report_mismatch(name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			report_mismatch(name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			report_mismatch(name, exp, act);
		end
	endtask

	// ==================================================
	// Stimulus
	// ==================================================
	// Drive point 2 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic start_download(input logic [7:0] index);
		ioctl.download = 1'b1;
		ioctl.index = index;
		tick();
	endtask

	task automatic end_download();
		ioctl.download = 1'b0;
		tick();
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		ioctl.addr = addr;
		ioctl.data = data;
		ioctl.wr = 1'b1;
		tick();
		ioctl.wr = 1'b0;
	endtask

	task automatic wait_clear_done();
		int n;
		n = 0;
		while (clearing && n < 140000) begin
			tick();
			n++;
		end
		if (clearing) begin
			errors++;
			$display("Timeout while waiting for the RAM clear sweep to finish");
		end
	endtask

	// ==================================================
	// Directed tests
	// ==================================================
	task automatic test_auto_header();
		logic [7:0] lo;
		logic [7:0] typ;
		cart_info_t exp;
		map_mode = MAP_AUTO;
		lo = 8'($urandom_range(255, 1));
		typ = 8'($urandom);
		start_download(8'h00);
		check_bit("system_reset", 1'b1, system_reset);
		write_word(25'd0, {typ, lo});
		tick();
		exp.rom_type = typ;
		exp.rom_mask = size_mask(lo[3:0], 1'b0);
		exp.ram_mask = size_mask(lo[7:4], 1'b1);
		check_cart("cart", exp, cart);
		end_download();
	endtask

	task automatic test_forced_map(input map_mode_e mode, input logic [24:0] hdr,
		input logic [7:0] typ);
		logic [3:0] rom_code;
		logic [3:0] ram_code;
		cart_info_t exp;
		map_mode = mode;
		region_sel = REGION_AUTO;
		rom_code = 4'($urandom);
		ram_code = 4'($urandom);
		start_download(8'h00);
		write_word(25'd0, 16'($urandom));
		// Region bit set in the word at address 2
		write_word(25'd2, 16'h0100);
		write_word(hdr + `SNES_HDR_SKIP, {4'h0, rom_code, 8'h00});
		write_word(hdr + `SNES_HDR_SKIP + 25'd2, {12'h000, ram_code});
		tick();
		exp.rom_type = typ;
		exp.rom_mask = size_mask(rom_code, 1'b0);
		exp.ram_mask = size_mask(ram_code, 1'b1);
		check_cart("cart", exp, cart);
		end_download();
		check_bit("pal", 1'b1, pal);
		region_sel = REGION_NTSC;
		tick();
		check_bit("pal", 1'b0, pal);
		region_sel = REGION_AUTO;
		map_mode = MAP_AUTO;
	endtask

	task automatic test_cheat();
		logic [15:0] words [8];
		cheat_code_t exp;
		start_download(`SNES_IDX_CODE);
		// Code downloads do not hold the core in reset
		check_bit("system_reset", 1'b0, system_reset);
		for (int i = 0; i < 8; i++) begin
			words[i] = 16'($urandom);
			check_bit("cheat.valid", 1'b0, cheat.valid);
			write_word(25'(2 * i), words[i]);
		end
		exp.valid = 1'b1;
		exp.flags = {words[1], words[0]};
		exp.addr = {words[3], words[2]};
		exp.compare = {words[5], words[4]};
		exp.replace = {words[7], words[6]};
		check_cheat("cheat", exp, cheat);
		tick();
		check_bit("cheat.valid", 1'b0, cheat.valid);
		end_download();
	endtask

	task automatic test_spc_reset();
		start_download(8'h01);
		check_bit("system_reset", 1'b1, system_reset);
		end_download();
		check_bit("system_reset", 1'b0, system_reset);
	endtask

	task automatic test_clear();
		int n;
		wram_fill = FILL_9966;
		aram_fill = FILL_00FF;
		check_bit("clearing", 1'b0, clearing);
		start_download(8'h00);
		check_bit("clearing", 1'b1, clearing);
		n = 0;
		while (clearing && n < (1 << `SNES_CLEAR_BITS) + 8) begin
			check_addr("fill_addr", n[`SNES_CLEAR_BITS-1:0], fill_addr);
			check_byte("wram_data", expected_fill(wram_fill, n[`SNES_CLEAR_BITS-1:0]),
				wram_data);
			check_byte("aram_data", expected_fill(aram_fill, n[`SNES_CLEAR_BITS-1:0]),
				aram_data);
			check_bit("system_reset", 1'b1, system_reset);
			if (n == 1000) begin
				ioctl.download = 1'b0;
			end
			// Second half of the sweep under the constant patterns
			if (n == 65536) begin
				wram_fill = FILL_55;
				aram_fill = FILL_FF;
			end
			n++;
			tick();
		end
		if (clearing) begin
			errors++;
			$display("Timeout, clearing is still high after the full sweep length");
		end else if (n != (1 << `SNES_CLEAR_BITS)) begin
			errors++;
			$display("Clearing lasted %0d cycles instead of %0d", n, 1 << `SNES_CLEAR_BITS);
		end
		check_bit("system_reset", 1'b0, system_reset);
	endtask

	task automatic test_mixer();
		audio_sample_t corner_a [5] = '{16'sh7FFF, 16'sh8000, 16'sh7FFF, 16'sh8000, 16'sh4000};
		audio_sample_t corner_b [5] = '{16'sh7FFF, 16'sh8000, 16'sh0001, 16'shFFFF, 16'sh4000};
		stereo_t exp;
		for (int i = 0; i < 55; i++) begin
			if (i < 5) begin
				main_audio = '{left: corner_a[i], right: corner_a[4 - i]};
				aux_audio = '{left: corner_b[i], right: corner_b[4 - i]};
			end else begin
				main_audio = stereo_t'($urandom);
				aux_audio = stereo_t'($urandom);
			end
			exp.left = clip_sum(main_audio.left, aux_audio.left);
			exp.right = clip_sum(main_audio.right, aux_audio.right);
			tick();
			check_stereo("mix_audio", exp, mix_audio);
		end
	endtask

	initial begin
		void'($urandom(2238));
		errors = 0;
		checks = 0;
		RESET = 1'b1;
		ioctl = '0;
		map_mode = MAP_AUTO;
		region_sel = REGION_AUTO;
		wram_fill = FILL_9966;
		aram_fill = FILL_00FF;
		main_audio = '0;
		aux_audio = '0;
		repeat (8) tick();
		RESET = 1'b0;

		check_bit("clearing", 1'b0, clearing);
		check_bit("cheat.valid", 1'b0, cheat.valid);
		check_bit("pal", 1'b0, pal);
		check_stereo("mix_audio", '0, mix_audio);

		test_auto_header();
		test_forced_map(MAP_LOROM, `SNES_LOROM_HDR, 8'd0);
		test_forced_map(MAP_HIROM, `SNES_HIROM_HDR, 8'd1);
		wait_clear_done();
		test_cheat();
		test_spc_reset();
		test_clear();
		test_mixer();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+hw
hw/snes_loader_pkg.sv
hw/rom_header_detect.sv
hw/cheat_code_assembler.sv
hw/ram_clear_engine.sv
hw/audio_sat_mixer.sv
hw/snes_loader_top.sv
tb/tb_snes_loader.sv
